//--- hdl/wdma_dat_cfg.sv
// output precision config for the write-DMA data-input stage
// sampled on op_load, steers dispatch and NaN counting

`timescale 1ns/1ns

module wdma_dat_cfg import wdma_dat_in_pkg::*; (
  input  logic       nvdla_core_clk,
  input  logic       nvdla_core_rstn,
  input  logic       op_load,
  input  logic [1:0] reg2dp_out_precision,
  output out_prec_e  out_prec
);

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      out_prec <= OUT_INT8;
    end else if (op_load) begin
      case (reg2dp_out_precision)
        2'd0: out_prec <= OUT_INT8;
        2'd2: out_prec <= OUT_FP16;
        // 1 and the spare encoding both mean int16
        default: out_prec <= OUT_INT16;
      endcase
    end
  end

endmodule

//--- hdl/wdma_dat_in_cfg.svh
// write-DMA data-input stage
// widths and counts shared by the datapath blocks

`ifndef WDMA_DAT_IN_CFG_SVH
`define WDMA_DAT_IN_CFG_SVH

// beat and half-beat widths
`define WDMA_DP_DW       256
`define WDMA_HALF_DW     128

// split command payload, size field is beats minus one
`define WDMA_SPT_PD_W    15
`define WDMA_SPT_SIZE_W  14

`define WDMA_NUM_LANES   4
`define WDMA_ELEM_W      16
`define WDMA_NAN_CNT_W   32

`endif

//--- hdl/wdma_dat_in_pkg.sv
// write-DMA data-input stage
// shared types for config and steering

package wdma_dat_in_pkg;

  // ========================================
  // output precision
  // ========================================

  // register encoding 3 is folded into int16 by the config block
  typedef enum logic [1:0] {
    OUT_INT8  = 2'd0,
    OUT_INT16 = 2'd1,
    OUT_FP16  = 2'd2
  } out_prec_e;

endpackage

//--- hdl/wdma_dat_in_top.sv
// write-DMA data-input stage
// tracks split commands and steers 256-bit beats into four lane buffers

`timescale 1ns/1ns
`include "wdma_dat_in_cfg.svh"

module wdma_dat_in_top import wdma_dat_in_pkg::*; (
  input  logic                          nvdla_core_clk,
  input  logic                          nvdla_core_rstn,
  input  logic                          op_load,
  input  logic [1:0]                    reg2dp_out_precision,
  input  logic                          cmd2dat_spt_pvld,
  output logic                          cmd2dat_spt_prdy,
  input  logic [`WDMA_SPT_PD_W-1:0]     cmd2dat_spt_pd,
  input  logic                          sdp_dp2wdma_valid,
  output logic                          sdp_dp2wdma_ready,
  input  logic [`WDMA_DP_DW-1:0]        sdp_dp2wdma_pd,
  output logic                          dfifo0_rd_pvld,
  input  logic                          dfifo0_rd_prdy,
  output logic [`WDMA_DP_DW-1:0]        dfifo0_rd_pd,
  output logic                          dfifo1_rd_pvld,
  input  logic                          dfifo1_rd_prdy,
  output logic [`WDMA_DP_DW-1:0]        dfifo1_rd_pd,
  output logic                          dfifo2_rd_pvld,
  input  logic                          dfifo2_rd_prdy,
  output logic [`WDMA_DP_DW-1:0]        dfifo2_rd_pd,
  output logic                          dfifo3_rd_pvld,
  input  logic                          dfifo3_rd_prdy,
  output logic [`WDMA_DP_DW-1:0]        dfifo3_rd_pd,
  output logic [`WDMA_NAN_CNT_W-1:0]    dp2reg_status_nan_output_num
);

  out_prec_e                   out_prec;
  logic [1:0]                  beat_phase;
  logic                        in_dat_accept;
  logic [`WDMA_NUM_LANES-1:0]  lane_wr_pvld;
  logic [`WDMA_NUM_LANES-1:0]  lane_wr_prdy;
  logic [`WDMA_DP_DW-1:0]      lane0_wr_pd;
  logic [`WDMA_DP_DW-1:0]      lane1_wr_pd;
  logic [`WDMA_DP_DW-1:0]      lane2_wr_pd;
  logic [`WDMA_DP_DW-1:0]      lane3_wr_pd;

  // ========================================
  // config and command tracking
  // ========================================
  wdma_dat_cfg u_cfg (
    .nvdla_core_clk       (nvdla_core_clk),
    .nvdla_core_rstn      (nvdla_core_rstn),
    .op_load              (op_load),
    .reg2dp_out_precision (reg2dp_out_precision),
    .out_prec             (out_prec)
  );

  wdma_spt_tracker u_tracker (
    .nvdla_core_clk   (nvdla_core_clk),
    .nvdla_core_rstn  (nvdla_core_rstn),
    .cmd2dat_spt_pvld (cmd2dat_spt_pvld),
    .cmd2dat_spt_prdy (cmd2dat_spt_prdy),
    .cmd2dat_spt_pd   (cmd2dat_spt_pd),
    .in_dat_accept    (in_dat_accept),
    .spt_vld          (),
    .beat_phase       (beat_phase),
    .is_last_beat     ()
  );

  // ========================================
  // steering and status
  // ========================================
  wdma_lane_dispatch u_dispatch (
    .out_prec          (out_prec),
    .beat_phase        (beat_phase),
    .sdp_dp2wdma_valid (sdp_dp2wdma_valid),
    .sdp_dp2wdma_ready (sdp_dp2wdma_ready),
    .sdp_dp2wdma_pd    (sdp_dp2wdma_pd),
    .in_dat_accept     (in_dat_accept),
    .lane_wr_pvld      (lane_wr_pvld),
    .lane_wr_prdy      (lane_wr_prdy),
    .lane0_wr_pd       (lane0_wr_pd),
    .lane1_wr_pd       (lane1_wr_pd),
    .lane2_wr_pd       (lane2_wr_pd),
    .lane3_wr_pd       (lane3_wr_pd)
  );

  wdma_nan_counter u_nan_cnt (
    .nvdla_core_clk               (nvdla_core_clk),
    .nvdla_core_rstn              (nvdla_core_rstn),
    .op_load                      (op_load),
    .out_prec                     (out_prec),
    .in_dat_accept                (in_dat_accept),
    .sdp_dp2wdma_pd               (sdp_dp2wdma_pd),
    .dp2reg_status_nan_output_num (dp2reg_status_nan_output_num)
  );

  // ========================================
  // lane buffers
  // ========================================
  wdma_lane_fifo u_dfifo0 (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .wr_pvld         (lane_wr_pvld[0]),
    .wr_prdy         (lane_wr_prdy[0]),
    .wr_pd           (lane0_wr_pd),
    .rd_pvld         (dfifo0_rd_pvld),
    .rd_prdy         (dfifo0_rd_prdy),
    .rd_pd           (dfifo0_rd_pd)
  );

  wdma_lane_fifo u_dfifo1 (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .wr_pvld         (lane_wr_pvld[1]),
    .wr_prdy         (lane_wr_prdy[1]),
    .wr_pd           (lane1_wr_pd),
    .rd_pvld         (dfifo1_rd_pvld),
    .rd_prdy         (dfifo1_rd_prdy),
    .rd_pd           (dfifo1_rd_pd)
  );

  wdma_lane_fifo u_dfifo2 (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .wr_pvld         (lane_wr_pvld[2]),
    .wr_prdy         (lane_wr_prdy[2]),
    .wr_pd           (lane2_wr_pd),
    .rd_pvld         (dfifo2_rd_pvld),
    .rd_prdy         (dfifo2_rd_prdy),
    .rd_pd           (dfifo2_rd_pd)
  );

  wdma_lane_fifo u_dfifo3 (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .wr_pvld         (lane_wr_pvld[3]),
    .wr_prdy         (lane_wr_prdy[3]),
    .wr_pd           (lane3_wr_pd),
    .rd_pvld         (dfifo3_rd_pvld),
    .rd_prdy         (dfifo3_rd_prdy),
    .rd_pd           (dfifo3_rd_pd)
  );

endmodule

//--- hdl/wdma_lane_dispatch.sv
// lane steering for the write-DMA data-input stage
// picks lane enables from precision and beat phase, forms lane payloads

`timescale 1ns/1ns
`include "wdma_dat_in_cfg.svh"

module wdma_lane_dispatch import wdma_dat_in_pkg::*; (
  input  out_prec_e                    out_prec,
  input  logic [1:0]                   beat_phase,
  input  logic                         sdp_dp2wdma_valid,
  output logic                         sdp_dp2wdma_ready,
  input  logic [`WDMA_DP_DW-1:0]       sdp_dp2wdma_pd,
  output logic                         in_dat_accept,
  output logic [`WDMA_NUM_LANES-1:0]   lane_wr_pvld,
  input  logic [`WDMA_NUM_LANES-1:0]   lane_wr_prdy,
  output logic [`WDMA_DP_DW-1:0]       lane0_wr_pd,
  output logic [`WDMA_DP_DW-1:0]       lane1_wr_pd,
  output logic [`WDMA_DP_DW-1:0]       lane2_wr_pd,
  output logic [`WDMA_DP_DW-1:0]       lane3_wr_pd
);

  logic [`WDMA_NUM_LANES-1:0] lane_en;
  logic [`WDMA_DP_DW-1:0]     upper_half;
  logic                       wide_mode;

  // ========================================
  // lane enables
  // ========================================
  always_comb begin
    lane_en = '0;
    case (out_prec)
      // int8 rotates one lane per beat
      OUT_INT8: lane_en[beat_phase] = 1'b1;
      default: begin
        // 16-bit modes write a lane pair per beat
        if (beat_phase[0]) begin
          lane_en = 4'b1100;
        end else begin
          lane_en = 4'b0011;
        end
      end
    endcase
  end

  // ========================================
  // payloads
  // ========================================
  assign wide_mode  = (out_prec != OUT_INT8);
  assign upper_half = {{`WDMA_HALF_DW{1'b0}},
                       sdp_dp2wdma_pd[`WDMA_DP_DW-1:`WDMA_HALF_DW]};

  assign lane0_wr_pd = sdp_dp2wdma_pd;
  assign lane2_wr_pd = sdp_dp2wdma_pd;
  // odd lanes carry the upper half in 16-bit modes
  assign lane1_wr_pd = wide_mode ? upper_half : sdp_dp2wdma_pd;
  assign lane3_wr_pd = wide_mode ? upper_half : sdp_dp2wdma_pd;

  // every enabled lane must have room, so a pair is written together or not at all
  assign sdp_dp2wdma_ready = &(lane_wr_prdy | ~lane_en);
  assign in_dat_accept     = sdp_dp2wdma_valid & sdp_dp2wdma_ready;
  assign lane_wr_pvld      = lane_en & {`WDMA_NUM_LANES{in_dat_accept}};

endmodule

//--- hdl/wdma_lane_fifo.sv
// two-entry skid buffer for one output lane
// registered read side, write ready comes straight from a flop

`timescale 1ns/1ns
`include "wdma_dat_in_cfg.svh"

module wdma_lane_fifo #(
  parameter int DW = `WDMA_DP_DW
) (
  input  logic          nvdla_core_clk,
  input  logic          nvdla_core_rstn,
  input  logic          wr_pvld,
  output logic          wr_prdy,
  input  logic [DW-1:0] wr_pd,
  output logic          rd_pvld,
  input  logic          rd_prdy,
  output logic [DW-1:0] rd_pd
);

  logic          out_vld;
  logic [DW-1:0] out_pd;
  logic          skid_vld;
  logic [DW-1:0] skid_pd;
  logic          wr_accept;
  logic          out_load;

  assign wr_prdy   = ~skid_vld;
  assign wr_accept = wr_pvld & wr_prdy;
  // output slot empty or draining this cycle
  assign out_load  = ~out_vld | rd_prdy;

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      out_vld  <= 1'b0;
      skid_vld <= 1'b0;
    end else if (out_load) begin
      // skid entry drains first to keep order
      out_vld  <= skid_vld | wr_accept;
      skid_vld <= 1'b0;
    end else if (wr_accept) begin
      skid_vld <= 1'b1;
    end
  end

  always_ff @(posedge nvdla_core_clk) begin
    if (out_load && (skid_vld || wr_accept)) begin
      out_pd <= skid_vld ? skid_pd : wr_pd;
    end
    if (!out_load && wr_accept) begin
      skid_pd <= wr_pd;
    end
  end

  assign rd_pvld = out_vld;
  assign rd_pd   = out_pd;

  // dispatch only writes a lane once every enabled lane has room
  a_no_wr_when_full: assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    wr_pvld |-> wr_prdy)
    else $error("lane buffer written while full");

endmodule

//--- hdl/wdma_nan_counter.sv
// fp16 NaN status counter
// counts NaN elements of each accepted beat, saturating, cleared on op_load

`timescale 1ns/1ns
`include "wdma_dat_in_cfg.svh"

module wdma_nan_counter import wdma_dat_in_pkg::*; (
  input  logic                         nvdla_core_clk,
  input  logic                         nvdla_core_rstn,
  input  logic                         op_load,
  input  out_prec_e                    out_prec,
  input  logic                         in_dat_accept,
  input  logic [`WDMA_DP_DW-1:0]       sdp_dp2wdma_pd,
  output logic [`WDMA_NAN_CNT_W-1:0]   dp2reg_status_nan_output_num
);

  localparam int NUM_ELEM = `WDMA_DP_DW / `WDMA_ELEM_W;
  localparam int NUM_W    = $clog2(NUM_ELEM + 1);
  // fp16 field layout
  localparam int MAN_W    = 10;
  localparam int EXP_W    = 5;

  logic [NUM_W-1:0]           nan_num;
  logic [`WDMA_NAN_CNT_W-1:0] nan_cnt;
  logic [`WDMA_NAN_CNT_W-1:0] cnt_sum;
  logic                       cnt_carry;
  logic                       cnt_en;

  // exponent all ones with nonzero mantissa, infinities excluded
  always_comb begin
    nan_num = '0;
    for (int i = 0; i < NUM_ELEM; i++) begin
      if ((&sdp_dp2wdma_pd[i*`WDMA_ELEM_W+MAN_W +: EXP_W]) &&
          (|sdp_dp2wdma_pd[i*`WDMA_ELEM_W +: MAN_W])) begin
        nan_num = nan_num + NUM_W'(1);
      end
    end
  end

  assign cnt_en = in_dat_accept & (out_prec == OUT_FP16);
  assign {cnt_carry, cnt_sum} = {1'b0, nan_cnt} + (`WDMA_NAN_CNT_W+1)'(nan_num);

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      nan_cnt <= '0;
    end else if (op_load) begin
      nan_cnt <= '0;
    end else if (cnt_en) begin
      nan_cnt <= cnt_carry ? '1 : cnt_sum;
    end
  end

  assign dp2reg_status_nan_output_num = nan_cnt;

endmodule

//--- hdl/wdma_spt_tracker.sv
// split command tracker
// holds the current command and counts its beats, releasing it on the last one

`timescale 1ns/1ns
`include "wdma_dat_in_cfg.svh"

module wdma_spt_tracker (
  input  logic                       nvdla_core_clk,
  input  logic                       nvdla_core_rstn,
  input  logic                       cmd2dat_spt_pvld,
  output logic                       cmd2dat_spt_prdy,
  input  logic [`WDMA_SPT_PD_W-1:0]  cmd2dat_spt_pd,
  input  logic                       in_dat_accept,
  output logic                       spt_vld,
  output logic [1:0]                 beat_phase,
  output logic                       is_last_beat
);

  logic [`WDMA_SPT_SIZE_W-1:0] spt_size;
  logic [`WDMA_SPT_SIZE_W-1:0] beat_count;
  logic                        spt_accept;

  // free slot, or the held command finishes this cycle
  assign cmd2dat_spt_prdy = ~spt_vld | (in_dat_accept & is_last_beat);
  assign spt_accept       = cmd2dat_spt_pvld & cmd2dat_spt_prdy;

  // ========================================
  // command register
  // ========================================
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      spt_vld  <= 1'b0;
      spt_size <= '0;
    end else begin
      if (cmd2dat_spt_prdy) begin
        spt_vld <= cmd2dat_spt_pvld;
      end
      // odd flag in the top bit is not used here
      if (spt_accept) begin
        spt_size <= cmd2dat_spt_pd[`WDMA_SPT_SIZE_W-1:0];
      end
    end
  end

  // ========================================
  // beat counter
  // ========================================
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      beat_count <= '0;
    end else if (in_dat_accept) begin
      if (is_last_beat) begin
        beat_count <= '0;
      end else begin
        beat_count <= beat_count + 1'b1;
      end
    end
  end

  assign is_last_beat = (beat_count == spt_size);
  assign beat_phase   = beat_count[1:0];

  a_dat_in_cmd: assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    in_dat_accept |-> spt_vld)
    else $error("data beat accepted while no split command is held");

endmodule

//--- sim/tb_clk_gen.sv
// clock and reset source for the testbench
// 10 ns clock, reset held low for 16 cycles

`timescale 1ns/1ns

module tb_clk_gen (
  output logic nvdla_core_clk,
  output logic nvdla_core_rstn
);

  initial begin
    nvdla_core_clk = 1'b0;
    forever begin
      #5 nvdla_core_clk = ~nvdla_core_clk;
    end
  end

  // release away from the rising edge
  initial begin
    nvdla_core_rstn = 1'b0;
    repeat (16) @(posedge nvdla_core_clk);
    @(negedge nvdla_core_clk);
    nvdla_core_rstn = 1'b1;
  end

endmodule

//--- sim/wdma_dat_in_tb.sv
// testbench for the write-DMA data-input stage
// directed tests against a per-lane reference model, with a cycle limit

`timescale 1ns/1ns
`include "wdma_dat_in_cfg.svh"

module wdma_dat_in_tb;

  localparam int DW = `WDMA_DP_DW;
  localparam int HW = `WDMA_HALF_DW;
  // about 50 beats in five tests plus reset, drains and a stall,
  // a few hundred cycles in all, so this leaves a wide margin
  localparam int TIMEOUT_CYCLES = 4000;
  localparam int DRAIN_LIMIT    = 200;

  logic                      nvdla_core_clk;
  logic                      nvdla_core_rstn;
  logic                      op_load;
  logic [1:0]                reg2dp_out_precision;
  logic                      cmd2dat_spt_pvld;
  logic                      cmd2dat_spt_prdy;
  logic [`WDMA_SPT_PD_W-1:0] cmd2dat_spt_pd;
  logic                      sdp_dp2wdma_valid;
  logic                      sdp_dp2wdma_ready;
  logic [DW-1:0]             sdp_dp2wdma_pd;
  logic [3:0]                rd_pvld;
  logic [3:0]                rd_prdy;
  logic [3:0][DW-1:0]        rd_pd;
  logic [31:0]               nan_num;

  logic [31:0] lcg_state;
  int          errors;
  int          checks;
  int          tests_run;
  int          tests_failed;
  int          err_mark;
  int          cycle_cnt;
  int          lane_rx_cnt [4];
  logic        saw_stall;

  // reference model state
  logic                        model_int8;
  int                          model_beat;
  logic [`WDMA_SPT_SIZE_W-1:0] model_size_q [$];
  logic [DW-1:0]               ref_q0 [$];
  logic [DW-1:0]               ref_q1 [$];
  logic [DW-1:0]               ref_q2 [$];
  logic [DW-1:0]               ref_q3 [$];
  logic [DW-1:0]               beat_q [$];

  tb_clk_gen u_clk (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn)
  );

  wdma_dat_in_top DUT (
    .nvdla_core_clk               (nvdla_core_clk),
    .nvdla_core_rstn              (nvdla_core_rstn),
    .op_load                      (op_load),
    .reg2dp_out_precision         (reg2dp_out_precision),
    .cmd2dat_spt_pvld             (cmd2dat_spt_pvld),
    .cmd2dat_spt_prdy             (cmd2dat_spt_prdy),
    .cmd2dat_spt_pd               (cmd2dat_spt_pd),
    .sdp_dp2wdma_valid            (sdp_dp2wdma_valid),
    .sdp_dp2wdma_ready            (sdp_dp2wdma_ready),
    .sdp_dp2wdma_pd               (sdp_dp2wdma_pd),
    .dfifo0_rd_pvld               (rd_pvld[0]),
    .dfifo0_rd_prdy               (rd_prdy[0]),
    .dfifo0_rd_pd                 (rd_pd[0]),
    .dfifo1_rd_pvld               (rd_pvld[1]),
    .dfifo1_rd_prdy               (rd_prdy[1]),
    .dfifo1_rd_pd                 (rd_pd[1]),
    .dfifo2_rd_pvld               (rd_pvld[2]),
    .dfifo2_rd_prdy               (rd_prdy[2]),
    .dfifo2_rd_pd                 (rd_pd[2]),
    .dfifo3_rd_pvld               (rd_pvld[3]),
    .dfifo3_rd_prdy               (rd_prdy[3]),
    .dfifo3_rd_pd                 (rd_pd[3]),
    .dp2reg_status_nan_output_num (nan_num)
  );

  // ========================================
  // stimulus helpers
  // ========================================
  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic [DW-1:0] random_beat();
    logic [DW-1:0] beat;
    for (int i = 0; i < DW / 32; i++) begin
      beat[i*32 +: 32] = lcg_next();
    end
    return beat;
  endfunction

  // nan_n NaNs first, then inf_n infinities, the rest finite
  function automatic logic [DW-1:0] fp16_beat(input int nan_n, input int inf_n);
    logic [DW-1:0] beat;
    logic [31:0]   r;
    for (int i = 0; i < 16; i++) begin
      r = lcg_next();
      if (i < nan_n) begin
        beat[i*16 +: 16] = {r[15], 5'h1f, r[9:0] | 10'h001};
      end else if (i < nan_n + inf_n) begin
        beat[i*16 +: 16] = {r[15], 5'h1f, 10'h000};
      end else begin
        beat[i*16 +: 16] = {r[15], (r[20:16] == 5'h1f) ? 5'h1e : r[20:16], r[9:0]};
      end
    end
    return beat;
  endfunction

  task automatic fill_random(input int n);
    for (int i = 0; i < n; i++) begin
      beat_q.push_back(random_beat());
    end
  endtask

  // ========================================
  // checks and bookkeeping
  // ========================================
  task automatic check_value(input string name, input logic [DW-1:0] got,
                             input logic [DW-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR t=%0t %s got %0h exp %0h", $time, name, got, exp);
    end
  endtask

  task automatic report_fail(input string msg);
    errors++;
    $display("error at t=%0t: %s", $time, msg);
  endtask

  function automatic int ref_depth(input int lane);
    case (lane)
      0: return ref_q0.size();
      1: return ref_q1.size();
      2: return ref_q2.size();
      default: return ref_q3.size();
    endcase
  endfunction

  task automatic push_ref(input int lane, input logic [DW-1:0] pd);
    case (lane)
      0: ref_q0.push_back(pd);
      1: ref_q1.push_back(pd);
      2: ref_q2.push_back(pd);
      default: ref_q3.push_back(pd);
    endcase
  endtask

  task automatic pop_check(input int lane, input logic [DW-1:0] got);
    logic [DW-1:0] exp;
    if (ref_depth(lane) == 0) begin
      report_fail($sformatf("lane %0d put out a beat that was never routed to it", lane));
    end else begin
      case (lane)
        0: exp = ref_q0.pop_front();
        1: exp = ref_q1.pop_front();
        2: exp = ref_q2.pop_front();
        default: exp = ref_q3.pop_front();
      endcase
      lane_rx_cnt[lane]++;
      check_value($sformatf("dfifo%0d_rd_pd", lane), got, exp);
    end
  endtask

  // routing rule for one accepted beat
  task automatic model_beat_in(input logic [DW-1:0] pd);
    logic [1:0]    phase;
    logic [DW-1:0] upper;
    if (model_size_q.size() == 0) begin
      report_fail("data beat accepted while no split command was outstanding");
    end else begin
      phase = 2'(model_beat);
      upper = {{HW{1'b0}}, pd[DW-1:HW]};
      if (model_int8) begin
        push_ref(phase, pd);
      end else if (!phase[0]) begin
        push_ref(0, pd);
        push_ref(1, upper);
      end else begin
        push_ref(2, pd);
        push_ref(3, upper);
      end
      if (model_beat == model_size_q[0]) begin
        void'(model_size_q.pop_front());
        model_beat = 0;
      end else begin
        model_beat++;
      end
    end
  endtask

  // outputs first, they hold beats accepted on earlier edges
  always @(posedge nvdla_core_clk) begin
    if (nvdla_core_rstn) begin
      for (int i = 0; i < 4; i++) begin
        if (rd_pvld[i] && rd_prdy[i]) begin
          pop_check(i, rd_pd[i]);
        end
      end
      if (sdp_dp2wdma_valid && sdp_dp2wdma_ready) begin
        model_beat_in(sdp_dp2wdma_pd);
      end
      if (cmd2dat_spt_pvld && cmd2dat_spt_prdy) begin
        model_size_q.push_back(cmd2dat_spt_pd[`WDMA_SPT_SIZE_W-1:0]);
      end
      if (op_load) begin
        model_int8 = (reg2dp_out_precision == 2'd0);
      end
    end
  end

  always @(posedge nvdla_core_clk) begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  // ========================================
  // bus drivers
  // ========================================
  task automatic send_cmd(input int size);
    @(negedge nvdla_core_clk);
    cmd2dat_spt_pvld = 1'b1;
    cmd2dat_spt_pd   = {1'b0, `WDMA_SPT_SIZE_W'(size)};
    @(posedge nvdla_core_clk);
    while (!cmd2dat_spt_prdy) begin
      @(posedge nvdla_core_clk);
    end
  endtask

  task automatic cmd_idle();
    @(negedge nvdla_core_clk);
    cmd2dat_spt_pvld = 1'b0;
  endtask

  // streams beat_q back to back
  task automatic send_beats();
    while (beat_q.size() > 0) begin
      @(negedge nvdla_core_clk);
      sdp_dp2wdma_valid = 1'b1;
      sdp_dp2wdma_pd    = beat_q.pop_front();
      @(posedge nvdla_core_clk);
      while (!sdp_dp2wdma_ready) begin
        @(posedge nvdla_core_clk);
      end
    end
    @(negedge nvdla_core_clk);
    sdp_dp2wdma_valid = 1'b0;
  endtask

  task automatic load_precision(input logic [1:0] prec);
    @(negedge nvdla_core_clk);
    op_load              = 1'b1;
    reg2dp_out_precision = prec;
    @(negedge nvdla_core_clk);
    op_load = 1'b0;
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    @(negedge nvdla_core_clk);
    while ((ref_depth(0) + ref_depth(1) + ref_depth(2) + ref_depth(3)) != 0 &&
           n < DRAIN_LIMIT) begin
      @(negedge nvdla_core_clk);
      n++;
    end
    if (n >= DRAIN_LIMIT) begin
      report_fail("lane outputs did not drain in time");
    end
    repeat (2) @(negedge nvdla_core_clk);
  endtask

  task automatic check_counts(input int c0, input int c1, input int c2, input int c3);
    check_value("dfifo0 beat count", lane_rx_cnt[0], c0);
    check_value("dfifo1 beat count", lane_rx_cnt[1], c1);
    check_value("dfifo2 beat count", lane_rx_cnt[2], c2);
    check_value("dfifo3 beat count", lane_rx_cnt[3], c3);
  endtask

  task automatic start_test();
    err_mark = errors;
    for (int i = 0; i < 4; i++) begin
      lane_rx_cnt[i] = 0;
    end
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (errors == err_mark) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: %0d errors", name, errors - err_mark);
    end
  endtask

  // ========================================
  // directed tests
  // ========================================
  task automatic test_int8_routing();
    start_test();
    send_cmd(7);
    cmd_idle();
    fill_random(8);
    send_beats();
    wait_drain();
    check_counts(2, 2, 2, 2);
    end_test("int8_routing");
  endtask

  task automatic test_int16_pairing();
    start_test();
    load_precision(2'd1);
    send_cmd(5);
    cmd_idle();
    fill_random(6);
    send_beats();
    wait_drain();
    check_counts(3, 3, 3, 3);
    end_test("int16_pairing");
  endtask

  // sizes 0, 2, 5, the next command waits on the last beat of the one before
  task automatic test_cmd_chain();
    start_test();
    load_precision(2'd0);
    send_cmd(0);
    fill_random(10);
    fork
      begin
        send_cmd(2);
        send_cmd(5);
        cmd_idle();
      end
      send_beats();
    join
    wait_drain();
    // phases 0 | 0 1 2 | 0 1 2 3 0 1
    check_counts(4, 3, 2, 1);
    check_value("cmd2dat_spt_prdy", cmd2dat_spt_prdy, 1'b1);
    end_test("cmd_chain");
  endtask

  task automatic test_backpressure();
    int n;
    start_test();
    saw_stall = 1'b0;
    n = 0;
    @(negedge nvdla_core_clk);
    rd_prdy[2] = 1'b0;
    send_cmd(15);
    cmd_idle();
    fill_random(16);
    fork
      send_beats();
      begin
        while (!saw_stall && n < 64) begin
          @(posedge nvdla_core_clk);
          if (sdp_dp2wdma_valid && !sdp_dp2wdma_ready) begin
            saw_stall = 1'b1;
          end
          n++;
        end
        repeat (4) @(negedge nvdla_core_clk);
        rd_prdy[2] = 1'b1;
      end
    join
    if (!saw_stall) begin
      report_fail("sdp_dp2wdma_ready never fell while lane 2 was held");
    end
    wait_drain();
    check_counts(4, 4, 4, 4);
    end_test("backpressure");
  endtask

  task automatic test_nan_status();
    logic [DW-1:0] saved [5];
    saved[0] = fp16_beat(3, 2);
    saved[1] = fp16_beat(0, 5);
    saved[2] = fp16_beat(16, 0);
    saved[3] = fp16_beat(7, 9);
    saved[4] = fp16_beat(0, 0);
    start_test();
    load_precision(2'd2);
    send_cmd(4);
    cmd_idle();
    for (int i = 0; i < 5; i++) begin
      beat_q.push_back(saved[i]);
    end
    send_beats();
    wait_drain();
    check_value("dp2reg_status_nan_output_num", nan_num, 3 + 16 + 7);
    // reload as int16 clears the count, and the same beats add nothing
    load_precision(2'd1);
    check_value("dp2reg_status_nan_output_num", nan_num, 0);
    send_cmd(4);
    cmd_idle();
    for (int i = 0; i < 5; i++) begin
      beat_q.push_back(saved[i]);
    end
    send_beats();
    wait_drain();
    check_value("dp2reg_status_nan_output_num", nan_num, 0);
    end_test("nan_status");
  endtask

  // ========================================
  // main sequence
  // ========================================
  initial begin
    lcg_state            = 32'h1898_2a53;
    errors               = 0;
    checks               = 0;
    tests_run            = 0;
    tests_failed         = 0;
    cycle_cnt            = 0;
    model_int8           = 1'b1;
    model_beat           = 0;
    op_load              = 1'b0;
    reg2dp_out_precision = 2'd0;
    cmd2dat_spt_pvld     = 1'b0;
    cmd2dat_spt_pd       = '0;
    sdp_dp2wdma_valid    = 1'b0;
    sdp_dp2wdma_pd       = '0;
    rd_prdy              = 4'hf;
    wait (nvdla_core_rstn === 1'b1);
    test_int8_routing();
    test_int16_pairing();
    test_cmd_chain();
    test_backpressure();
    test_nan_status();
    $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

//--- wdma_dat_in.f
+incdir+hdl
hdl/wdma_dat_in_pkg.sv
hdl/wdma_dat_cfg.sv
hdl/wdma_spt_tracker.sv
hdl/wdma_lane_dispatch.sv
hdl/wdma_nan_counter.sv
hdl/wdma_lane_fifo.sv
hdl/wdma_dat_in_top.sv
sim/tb_clk_gen.sv
sim/wdma_dat_in_tb.sv
